//--- Bender.yml
package:
  name: fetch_front_end

sources:
  - common/fetch_pkg.sv
  - rtl/fetch_addr_xlate.sv
  - fetch/pre_if_stage.sv
  - fetch/if_stage.sv
  - rtl/fetch_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/fetch_tb.sv

//--- common/fetch_pkg.sv
package fetch_pkg;

    // bus widths
    localparam int unsigned pc_w    = 32;
    localparam int unsigned inst_w  = 32;
    localparam int unsigned ecode_w = 6;
    localparam int unsigned ps_w    = 6;
    localparam int unsigned plv_w   = 2;
    localparam int unsigned seg_w   = 3;   // direct map window segment
    localparam int unsigned ppn_w   = 20;
    localparam int unsigned vppn_w  = 19;  // tlb lookup key from va[31:13]

    // the first sequential fetch lands on 1c000000
    localparam logic [pc_w-1:0] reset_pc = 32'h1bff_fffc;

    // fetch exception codes
    localparam logic [ecode_w-1:0] ecode_adef = 6'h08;  // misaligned pc
    localparam logic [ecode_w-1:0] ecode_tlbr = 6'h3f;  // tlb refill
    localparam logic [ecode_w-1:0] ecode_pif  = 6'h03;  // page invalid on fetch
    localparam logic [ecode_w-1:0] ecode_ppi  = 6'h07;  // privilege violation

    // page size code that selects a 4 MB page instead of 4 KB
    localparam logic [ps_w-1:0] ps_4m = 6'd21;

endpackage

//--- fetch/if_stage.sv
`timescale 1ns/1ps

module if_stage (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [fetch_pkg::pc_w-1:0]    pre_pc,
    input  logic                          pre_ready,
    input  logic                          pre_reqed,
    input  logic                          pre_ir_valid,
    input  logic [fetch_pkg::inst_w-1:0]  pre_ir,
    input  logic                          pre_excep_en,
    input  logic [fetch_pkg::ecode_w-1:0] pre_ecode,
    input  logic                          inst_sram_data_ok,
    input  logic [fetch_pkg::inst_w-1:0]  inst_sram_rdata,
    input  logic                          id_allowin,
    input  logic                          br_taken,
    input  logic                          flush,
    output logic                          if_allowin,
    output logic [fetch_pkg::pc_w-1:0]    if_pc,
    output logic                          if_ir_valid,
    output logic                          if_to_id_valid,
    output logic [fetch_pkg::inst_w-1:0]  if_inst,
    output logic                          if_excep_en,
    output logic [fetch_pkg::ecode_w-1:0] if_ecode,
    output logic [fetch_pkg::pc_w-1:0]    if_badv
);

    logic                         if_valid;
    logic                         if_cancel;   // next data_ok is wrong-path
    logic [fetch_pkg::inst_w-1:0] if_ir;
    logic                         if_wait;
    logic                         if_ready_go;
    logic                         move;
    logic                         move_fresh;  // pre-IF hands over a new pc
    logic                         kill;
    logic                         buf_own;
    logic                         buf_move;

    assign if_wait     = if_valid & ~if_ir_valid & ~if_excep_en;
    assign if_ready_go = if_ir_valid | if_excep_en | inst_sram_data_ok & ~if_cancel;
    // hold off new work until the dropped response is back
    assign if_allowin  = (~if_valid | if_ready_go & id_allowin)
                       & (~if_cancel | inst_sram_data_ok);

    assign move       = pre_ready & if_allowin;
    assign move_fresh = move & ~pre_reqed;
    assign kill       = (flush | br_taken) & ~move_fresh;

    assign if_to_id_valid = if_valid & if_ready_go;
    assign if_inst        = if_ir_valid ? if_ir : inst_sram_rdata;  // bypass fresh data
    assign if_badv        = if_excep_en ? if_pc : '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid <= 1'b0;
        end else if (kill) begin
            if_valid <= 1'b0;
        end else if (move) begin
            if_valid <= 1'b1;
        end else if (if_to_id_valid & id_allowin) begin
            if_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_pc       <= fetch_pkg::reset_pc;
            if_excep_en <= 1'b0;
        end else if (move) begin
            if_pc       <= pre_pc;
            if_excep_en <= pre_excep_en;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            if_ecode <= pre_ecode;
        end
    end

    // decode stalled on our own response, or the incoming item already has data
    assign buf_own  = if_wait & inst_sram_data_ok & ~id_allowin;
    assign buf_move = move & (pre_reqed & (pre_ir_valid | inst_sram_data_ok)
                    | move_fresh & ~pre_excep_en & inst_sram_data_ok & ~if_cancel & ~if_wait);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_ir_valid <= 1'b0;
        end else if (kill) begin
            if_ir_valid <= 1'b0;
        end else if (buf_own | buf_move) begin
            if_ir_valid <= 1'b1;
        end else if (move | if_to_id_valid & id_allowin) begin
            if_ir_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_own | buf_move) begin
            if_ir <= (move & pre_reqed & pre_ir_valid) ? pre_ir : inst_sram_rdata;
        end
    end

    // a redirect with a response still in flight drops that response
    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_cancel <= 1'b0;
        end else if ((flush | br_taken) & ~inst_sram_data_ok
                     & (if_wait | pre_reqed & ~pre_ir_valid)) begin
            if_cancel <= 1'b1;
        end else if (inst_sram_data_ok) begin
            if_cancel <= 1'b0;
        end
    end

    a_data_ok_owned: assert property (@(posedge clk) disable iff (!resetn)
        inst_sram_data_ok |-> (if_cancel | if_wait | pre_reqed & ~pre_ir_valid
                              | pre_ready & ~pre_reqed & ~pre_excep_en))
        else $error("data_ok with no request outstanding");

    a_hold_on_stall: assert property (@(posedge clk) disable iff (!resetn)
        if_to_id_valid && !id_allowin && !flush && !br_taken
        |=> if_to_id_valid && $stable(if_pc) && $stable(if_inst))
        else $error("instruction lost or changed under decode stall");

endmodule

//--- fetch/pre_if_stage.sv
`timescale 1ns/1ps

module pre_if_stage (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         br_taken,
    input  logic [fetch_pkg::pc_w-1:0]   br_target,
    input  logic                         br_stall,
    input  logic                         flush,
    input  logic [fetch_pkg::pc_w-1:0]   flush_entry,
    input  logic                         if_allowin,
    input  logic [fetch_pkg::pc_w-1:0]   if_pc,
    input  logic                         if_ir_valid,
    input  logic [fetch_pkg::pc_w-1:0]   pre_pa,
    input  logic                         pre_excep_en,
    input  logic                         inst_sram_addr_ok,
    input  logic                         inst_sram_data_ok,
    input  logic [fetch_pkg::inst_w-1:0] inst_sram_rdata,
    output logic [fetch_pkg::pc_w-1:0]   pre_pc,
    output logic                         inst_sram_req,
    output logic [fetch_pkg::pc_w-1:0]   inst_sram_addr,
    output logic                         pre_ready,
    output logic                         pre_reqed,
    output logic                         pre_ir_valid,
    output logic [fetch_pkg::inst_w-1:0] pre_ir
);

    logic                       started;      // low in the first cycle after reset
    logic                       flush_hold;
    logic [fetch_pkg::pc_w-1:0] flush_hold_pc;
    logic                       br_hold;
    logic [fetch_pkg::pc_w-1:0] br_hold_pc;
    logic                       redirect;
    logic                       accept;
    logic                       taken;        // fresh pc handed to IF
    logic                       capture;

    assign redirect = flush | br_taken;
    assign accept   = inst_sram_req & inst_sram_addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    always_comb begin
        if (flush_hold) begin
            pre_pc = flush_hold_pc;
        end else if (flush) begin
            pre_pc = flush_entry;
        end else if (br_hold) begin
            pre_pc = br_hold_pc;
        end else if (br_taken) begin
            pre_pc = br_target;
        end else begin
            pre_pc = if_pc + (fetch_pkg::pc_w)'(4);
        end
    end

    // a live redirect only goes out if IF takes it in the same cycle
    assign inst_sram_req = started & ~pre_reqed & ~br_stall & ~pre_excep_en
                         & (if_allowin | ~redirect & (inst_sram_data_ok | if_ir_valid));
    assign inst_sram_addr = pre_pa;

    assign pre_ready = started & (pre_reqed | accept | pre_excep_en & ~br_stall);
    assign taken     = pre_ready & if_allowin & ~pre_reqed;

    // redirect targets wait here until they reach IF
    always_ff @(posedge clk) begin
        if (!resetn) begin
            flush_hold <= 1'b0;
        end else if (taken) begin
            flush_hold <= 1'b0;
        end else if (flush) begin
            flush_hold <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            br_hold <= 1'b0;
        end else if (taken | flush) begin
            br_hold <= 1'b0;   // flush overrides a pending branch
        end else if (br_taken) begin
            br_hold <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            flush_hold_pc <= flush_entry;
        end
        if (br_taken) begin
            br_hold_pc <= br_target;
        end
    end

    // own request accepted while IF was full
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_reqed <= 1'b0;
        end else if (redirect | pre_ready & if_allowin) begin
            pre_reqed <= 1'b0;
        end else if (accept) begin
            pre_reqed <= 1'b1;
        end
    end

    // response for pre-IF arriving while IF cannot take it
    assign capture = inst_sram_data_ok & ~if_allowin
                   & (pre_reqed & ~pre_ir_valid | accept & if_ir_valid);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_ir_valid <= 1'b0;
        end else if (redirect | pre_ready & if_allowin) begin
            pre_ir_valid <= 1'b0;
        end else if (capture) begin
            pre_ir_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pre_ir <= inst_sram_rdata;
        end
    end

    a_ir_owned: assert property (@(posedge clk) disable iff (!resetn)
        pre_ir_valid |-> pre_reqed)
        else $error("response buffered in pre-IF with no request owned");

    a_reqed_pc_stable: assert property (@(posedge clk) disable iff (!resetn)
        pre_reqed && !redirect |-> $stable(pre_pc))
        else $error("pc of the request held in pre-IF changed");

endmodule

//--- filelist.f
common/fetch_pkg.sv
rtl/fetch_addr_xlate.sv
fetch/pre_if_stage.sv
fetch/if_stage.sv
rtl/fetch_top.sv
verif/tb_clock_gen.sv
verif/fetch_tb.sv

//--- rtl/fetch_addr_xlate.sv
`timescale 1ns/1ps

module fetch_addr_xlate (
    input  logic [fetch_pkg::pc_w-1:0]    pre_pc,
    input  logic                          csr_crmd_pg,
    input  logic [fetch_pkg::plv_w-1:0]   csr_crmd_plv,
    input  logic                          csr_dmw0_plv_met,
    input  logic [fetch_pkg::seg_w-1:0]   csr_dmw0_vseg,
    input  logic [fetch_pkg::seg_w-1:0]   csr_dmw0_pseg,
    input  logic                          csr_dmw1_plv_met,
    input  logic [fetch_pkg::seg_w-1:0]   csr_dmw1_vseg,
    input  logic [fetch_pkg::seg_w-1:0]   csr_dmw1_pseg,
    input  logic                          s0_found,
    input  logic [fetch_pkg::ppn_w-1:0]   s0_ppn,
    input  logic [fetch_pkg::ps_w-1:0]    s0_ps,
    input  logic [fetch_pkg::plv_w-1:0]   s0_plv,
    input  logic                          s0_v,
    output logic [fetch_pkg::vppn_w-1:0]  s0_vppn,
    output logic                          s0_va_bit12,
    output logic [fetch_pkg::pc_w-1:0]    pre_pa,
    output logic                          pre_excep_en,
    output logic [fetch_pkg::ecode_w-1:0] pre_ecode
);

    logic hit_dmw0;
    logic hit_dmw1;
    logic tlb_mapped;
    logic excep_adef;
    logic excep_tlb;

    // tlb answers combinationally on the selected pc
    assign s0_vppn     = pre_pc[31:13];
    assign s0_va_bit12 = pre_pc[12];

    assign hit_dmw0   = csr_dmw0_plv_met & (csr_dmw0_vseg == pre_pc[31:29]);
    assign hit_dmw1   = csr_dmw1_plv_met & (csr_dmw1_vseg == pre_pc[31:29]);
    assign tlb_mapped = csr_crmd_pg & ~hit_dmw0 & ~hit_dmw1;  // paging on without a window hit

    always_comb begin
        if (!csr_crmd_pg) begin
            pre_pa = pre_pc;                                // direct address mode
        end else if (hit_dmw0) begin
            pre_pa = {csr_dmw0_pseg, pre_pc[28:0]};         // window 0 wins a double hit
        end else if (hit_dmw1) begin
            pre_pa = {csr_dmw1_pseg, pre_pc[28:0]};
        end else if (s0_ps == fetch_pkg::ps_4m) begin
            pre_pa = {s0_ppn[19:9], pre_pc[20:0]};          // 4 MB page
        end else begin
            pre_pa = {s0_ppn, pre_pc[11:0]};                // 4 KB page
        end
    end

    assign excep_adef = |pre_pc[1:0];
    assign excep_tlb  = tlb_mapped & (~s0_found | ~s0_v | (csr_crmd_plv > s0_plv));

    assign pre_excep_en = excep_adef | excep_tlb;

    // priority adef, tlbr, pif, ppi
    always_comb begin
        if (excep_adef) begin
            pre_ecode = fetch_pkg::ecode_adef;
        end else if (!s0_found) begin
            pre_ecode = fetch_pkg::ecode_tlbr;
        end else if (!s0_v) begin
            pre_ecode = fetch_pkg::ecode_pif;
        end else begin
            pre_ecode = fetch_pkg::ecode_ppi;
        end
    end

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                          clk,
    input  logic                          resetn,
    output logic                          inst_sram_req,
    output logic [fetch_pkg::pc_w-1:0]    inst_sram_addr,
    input  logic                          inst_sram_addr_ok,
    input  logic                          inst_sram_data_ok,
    input  logic [fetch_pkg::inst_w-1:0]  inst_sram_rdata,
    input  logic                          id_allowin,
    input  logic                          br_taken,
    input  logic [fetch_pkg::pc_w-1:0]    br_target,
    input  logic                          br_stall,
    output logic                          if_to_id_valid,
    output logic [fetch_pkg::pc_w-1:0]    if_pc_out,
    output logic [fetch_pkg::inst_w-1:0]  if_inst,
    output logic                          if_excep_en,
    output logic [fetch_pkg::ecode_w-1:0] if_ecode,
    output logic [fetch_pkg::pc_w-1:0]    if_badv,
    input  logic                          flush,
    input  logic [fetch_pkg::pc_w-1:0]    flush_entry,
    input  logic                          csr_crmd_pg,
    input  logic [fetch_pkg::plv_w-1:0]   csr_crmd_plv,
    input  logic                          csr_dmw0_plv_met,
    input  logic [fetch_pkg::seg_w-1:0]   csr_dmw0_vseg,
    input  logic [fetch_pkg::seg_w-1:0]   csr_dmw0_pseg,
    input  logic                          csr_dmw1_plv_met,
    input  logic [fetch_pkg::seg_w-1:0]   csr_dmw1_vseg,
    input  logic [fetch_pkg::seg_w-1:0]   csr_dmw1_pseg,
    input  logic                          s0_found,
    input  logic [fetch_pkg::ppn_w-1:0]   s0_ppn,
    input  logic [fetch_pkg::ps_w-1:0]    s0_ps,
    input  logic [fetch_pkg::plv_w-1:0]   s0_plv,
    input  logic                          s0_v,
    output logic [fetch_pkg::vppn_w-1:0]  s0_vppn,
    output logic                          s0_va_bit12
);

    logic [fetch_pkg::pc_w-1:0]    pre_pc;
    logic [fetch_pkg::pc_w-1:0]    pre_pa;
    logic                          pre_excep_en;
    logic [fetch_pkg::ecode_w-1:0] pre_ecode;
    logic                          pre_ready;
    logic                          pre_reqed;
    logic                          pre_ir_valid;
    logic [fetch_pkg::inst_w-1:0]  pre_ir;
    logic                          if_allowin;
    logic                          if_ir_valid;

    fetch_addr_xlate fetch_addr_xlate_inst (
        .pre_pc           (pre_pc),
        .csr_crmd_pg      (csr_crmd_pg),
        .csr_crmd_plv     (csr_crmd_plv),
        .csr_dmw0_plv_met (csr_dmw0_plv_met),
        .csr_dmw0_vseg    (csr_dmw0_vseg),
        .csr_dmw0_pseg    (csr_dmw0_pseg),
        .csr_dmw1_plv_met (csr_dmw1_plv_met),
        .csr_dmw1_vseg    (csr_dmw1_vseg),
        .csr_dmw1_pseg    (csr_dmw1_pseg),
        .s0_found         (s0_found),
        .s0_ppn           (s0_ppn),
        .s0_ps            (s0_ps),
        .s0_plv           (s0_plv),
        .s0_v             (s0_v),
        .s0_vppn          (s0_vppn),
        .s0_va_bit12      (s0_va_bit12),
        .pre_pa           (pre_pa),
        .pre_excep_en     (pre_excep_en),
        .pre_ecode        (pre_ecode)
    );

    pre_if_stage pre_if_stage_inst (
        .clk               (clk),
        .resetn            (resetn),
        .br_taken          (br_taken),
        .br_target         (br_target),
        .br_stall          (br_stall),
        .flush             (flush),
        .flush_entry       (flush_entry),
        .if_allowin        (if_allowin),
        .if_pc             (if_pc_out),
        .if_ir_valid       (if_ir_valid),
        .pre_pa            (pre_pa),
        .pre_excep_en      (pre_excep_en),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .pre_pc            (pre_pc),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .pre_ready         (pre_ready),
        .pre_reqed         (pre_reqed),
        .pre_ir_valid      (pre_ir_valid),
        .pre_ir            (pre_ir)
    );

    if_stage if_stage_inst (
        .clk               (clk),
        .resetn            (resetn),
        .pre_pc            (pre_pc),
        .pre_ready         (pre_ready),
        .pre_reqed         (pre_reqed),
        .pre_ir_valid      (pre_ir_valid),
        .pre_ir            (pre_ir),
        .pre_excep_en      (pre_excep_en),
        .pre_ecode         (pre_ecode),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .id_allowin        (id_allowin),
        .br_taken          (br_taken),
        .flush             (flush),
        .if_allowin        (if_allowin),
        .if_pc             (if_pc_out),
        .if_ir_valid       (if_ir_valid),
        .if_to_id_valid    (if_to_id_valid),
        .if_inst           (if_inst),
        .if_excep_en       (if_excep_en),
        .if_ecode          (if_ecode),
        .if_badv           (if_badv)
    );

endmodule

//--- verif/fetch_input.txt
// num mode pg plv d0met d0vseg d0pseg d1met d1vseg d1pseg found ppn ps s0plv v
//   kind rcycle target count exp_pc exp_ecode  (mode 1 random allowin, 2 br_stall)
// kind 0 none, 1 branch, 2 flush, 3 flush and branch together
01 0 0 0 0 0 0 0 0 0 0 00000 0c 0 0 0 0 00000000 0c 1c000000 00
02 1 0 0 0 0 0 0 0 0 0 00000 0c 0 0 0 0 00000000 14 1c000030 00
03 1 0 0 0 0 0 0 0 0 0 00000 0c 0 0 1 5 1c001000 0a 1c001000 00
04 3 0 0 0 0 0 0 0 0 0 00000 0c 0 0 1 3 1c002000 08 1c002000 00
05 1 0 0 0 0 0 0 0 0 0 00000 0c 0 0 2 4 1c003000 08 1c003000 00
06 1 0 0 0 0 0 0 0 0 0 00000 0c 0 0 3 2 1c004000 08 1c004000 00
07 1 1 0 1 4 0 0 0 0 0 00000 0c 0 0 2 3 80001000 08 80001000 00
08 1 1 0 1 5 1 1 5 2 0 00000 0c 0 0 2 3 a0002000 08 a0002000 00
09 1 1 0 0 0 0 0 0 0 1 12345 0c 3 1 2 3 00403000 08 00403000 00
0a 1 1 0 0 0 0 0 0 0 1 abcde 15 3 1 2 3 00705000 08 00705000 00
0b 1 0 0 0 0 0 0 0 0 0 00000 0c 0 0 2 3 1c005002 04 1c005002 08
0c 1 1 0 0 0 0 0 0 0 0 00000 0c 0 0 2 3 00800000 04 00800000 3f
0d 1 1 0 0 0 0 0 0 0 1 00800 0c 0 0 2 3 00801000 04 00801000 03
0e 1 1 3 0 0 0 0 0 0 1 00800 0c 0 1 2 3 00802000 04 00802000 07
0f 1 0 0 0 0 0 0 0 0 0 00000 0c 0 0 2 3 1c006000 0a 1c006000 00

//--- verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam int nf     = 21;                      // fields per test line
    localparam int ntests = 15;
    localparam logic [31:0] inst_key = 32'ha33c_5a5a;

    logic                          clk;
    logic                          resetn;
    logic                          inst_sram_req;
    logic [fetch_pkg::pc_w-1:0]    inst_sram_addr;
    logic                          inst_sram_addr_ok;
    logic                          inst_sram_data_ok;
    logic [fetch_pkg::inst_w-1:0]  inst_sram_rdata;
    logic                          id_allowin;
    logic                          br_taken;
    logic [fetch_pkg::pc_w-1:0]    br_target;
    logic                          br_stall;
    logic                          if_to_id_valid;
    logic [fetch_pkg::pc_w-1:0]    if_pc_out;
    logic [fetch_pkg::inst_w-1:0]  if_inst;
    logic                          if_excep_en;
    logic [fetch_pkg::ecode_w-1:0] if_ecode;
    logic [fetch_pkg::pc_w-1:0]    if_badv;
    logic                          flush;
    logic [fetch_pkg::pc_w-1:0]    flush_entry;
    logic                          csr_crmd_pg;
    logic [fetch_pkg::plv_w-1:0]   csr_crmd_plv;
    logic                          csr_dmw0_plv_met;
    logic [fetch_pkg::seg_w-1:0]   csr_dmw0_vseg;
    logic [fetch_pkg::seg_w-1:0]   csr_dmw0_pseg;
    logic                          csr_dmw1_plv_met;
    logic [fetch_pkg::seg_w-1:0]   csr_dmw1_vseg;
    logic [fetch_pkg::seg_w-1:0]   csr_dmw1_pseg;
    logic                          s0_found;
    logic [fetch_pkg::ppn_w-1:0]   s0_ppn;
    logic [fetch_pkg::ps_w-1:0]    s0_ps;
    logic [fetch_pkg::plv_w-1:0]   s0_plv;
    logic                          s0_v;
    logic [fetch_pkg::vppn_w-1:0]  s0_vppn;
    logic                          s0_va_bit12;

    logic [31:0] stim [0:nf*ntests-1];
    logic [31:0] rsp_addr [$];                       // accepted requests in order
    int          rsp_due [$];
    logic [31:0] rnd;
    logic [1:0]  lat;
    logic [31:0] last_pc;
    int          cyc;
    int          limit;
    int          cur_t;
    int          chk_t;                              // test whose settings apply to transfers
    int          ndone;
    int          checks;
    int          errors;
    bit          in_new;
    bit          want_first;
    bit          redir_now;
    bit          prev_resetn;

    tb_clock_gen tb_clock_gen_inst (
        .clk    (clk),
        .resetn (resetn)
    );

    fetch_top fetch_top_inst (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    // translation and exception rules of the fetch front end
    task automatic ref_fetch(input int t, input logic [31:0] pc,
                             output logic [31:0] pa, output logic [5:0] ec);
        int   b;
        logic win0;
        logic win1;
        b    = t * nf;
        win0 = stim[b+4][0] && (stim[b+5][2:0] == pc[31:29]);
        win1 = stim[b+7][0] && (stim[b+8][2:0] == pc[31:29]);
        ec   = 6'h00;
        if (!stim[b+2][0]) begin
            pa = pc;
        end else if (win0) begin
            pa = {stim[b+6][2:0], pc[28:0]};
        end else if (win1) begin
            pa = {stim[b+9][2:0], pc[28:0]};
        end else if (stim[b+12] == 21) begin
            pa = {stim[b+11][19:9], pc[20:0]};       // 4 MB page
        end else begin
            pa = {stim[b+11][19:0], pc[11:0]};
        end
        if (pc[1:0] != 2'b00) begin
            ec = fetch_pkg::ecode_adef;
        end else if (stim[b+2][0] && !win0 && !win1) begin
            if (!stim[b+10][0]) begin
                ec = fetch_pkg::ecode_tlbr;
            end else if (!stim[b+14][0]) begin
                ec = fetch_pkg::ecode_pif;
            end else if (stim[b+3] > stim[b+13]) begin
                ec = fetch_pkg::ecode_ppi;
            end
        end
    endtask

    task automatic apply_settings(input int t);
        int b;
        b = t * nf;
        csr_crmd_pg      = stim[b+2][0];
        csr_crmd_plv     = stim[b+3][1:0];
        csr_dmw0_plv_met = stim[b+4][0];
        csr_dmw0_vseg    = stim[b+5][2:0];
        csr_dmw0_pseg    = stim[b+6][2:0];
        csr_dmw1_plv_met = stim[b+7][0];
        csr_dmw1_vseg    = stim[b+8][2:0];
        csr_dmw1_pseg    = stim[b+9][2:0];
        s0_found         = stim[b+10][0];
        s0_ppn           = stim[b+11][19:0];
        s0_ps            = stim[b+12][5:0];
        s0_plv           = stim[b+13][1:0];
        s0_v             = stim[b+14][0];
    endtask

    // one clock step with inputs changed 2 ns after the edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
        rnd               = xorshift(rnd);
        inst_sram_addr_ok = rnd[0] | rnd[1];
        lat               = rnd[5:4];                // extra response delay 0..3
        id_allowin        = stim[cur_t*nf+1][0] ? rnd[9] : 1'b1;
        inst_sram_data_ok = (rsp_due.size() > 0) && (rsp_due[0] <= cyc);
        inst_sram_rdata   = inst_sram_data_ok ? rsp_addr[0] ^ inst_key : '0;
    endtask

    task automatic check_transfer();
        logic [31:0] exp_pc;
        logic [31:0] nxt_pc;
        logic [31:0] pa;
        logic [5:0]  ec;
        exp_pc = want_first ? stim[cur_t*nf+19] : last_pc + 32'd4;
        compare_hex("if_pc_out", exp_pc, if_pc_out);
        ref_fetch(chk_t, exp_pc, pa, ec);
        compare_hex("if_excep_en", ec != 6'h00, if_excep_en);
        if (ec != 6'h00) begin
            compare_hex("if_ecode", ec, if_ecode);
            compare_hex("if_badv", exp_pc, if_badv);
        end else begin
            compare_hex("if_inst", pa ^ inst_key, if_inst);
        end
        if (want_first) begin
            compare_hex("if_ecode", stim[cur_t*nf+20], if_excep_en ? if_ecode : 6'h00);
        end
        // without a redirect the tlb key comes from the next sequential pc
        if (!redir_now) begin
            nxt_pc = exp_pc + 32'd4;
            compare_hex("s0_vppn", nxt_pc[31:13], s0_vppn);
            compare_hex("s0_va_bit12", nxt_pc[12], s0_va_bit12);
        end
        if (in_new) begin
            ndone++;
        end
        want_first = 1'b0;
        last_pc    = exp_pc;
    endtask

    task automatic run_test(input int t);
        int          b;
        int          err0;
        logic [31:0] tgt;
        b          = t * nf;
        err0       = errors;
        tgt        = stim[b+17];
        cur_t      = t;
        ndone      = 0;
        in_new     = (stim[b+15] == 0);
        want_first = (stim[b+15] == 0);
        if (stim[b+15] != 0) begin
            repeat (stim[b+16]) step_cycle();
            apply_settings(t);
            flush       = stim[b+15][1];
            br_taken    = stim[b+15][0];
            flush_entry = tgt;
            br_target   = (stim[b+15] == 3) ? tgt ^ 32'h0000_0100 : tgt;  // losing branch
            br_stall    = stim[b+1][1];
            redir_now   = 1'b1;
            step_cycle();
            flush    = 1'b0;
            br_taken = 1'b0;
            if (br_stall) begin
                repeat (5) step_cycle();
                br_stall = 1'b0;
            end
        end
        while (ndone < stim[b+18]) step_cycle();
        $display("test %0d: %0d instructions counted, %0d errors", stim[b], ndone, errors - err0);
    endtask

    // sram responses, transfers and per-cycle rules
    always @(negedge clk) begin
        if (inst_sram_data_ok) begin
            rsp_addr.delete(0);
            rsp_due.delete(0);
        end
        if (inst_sram_req && inst_sram_addr_ok) begin
            rsp_addr.push_back(inst_sram_addr);
            rsp_due.push_back(cyc + 1 + lat);
        end
        if (!resetn || !prev_resetn) begin
            assert (!inst_sram_req && !if_to_id_valid) else begin
                $display("request or transfer seen during reset or the cycle after it");
                errors++;
            end
        end
        assert (!(br_stall && inst_sram_req)) else begin
            $display("SRAM request issued while br_stall was high");
            errors++;
        end
        if ((in_new || redir_now) && stim[cur_t*nf+20] != 0) begin
            assert (!inst_sram_req) else begin
                $display("SRAM request issued for a faulting fetch address");
                errors++;
            end
        end
        if (if_to_id_valid && id_allowin) begin
            check_transfer();
        end
        if (redir_now) begin
            chk_t      = cur_t;
            in_new     = 1'b1;
            want_first = 1'b1;
            redir_now  = 1'b0;
        end
        prev_resetn = resetn;
        cyc++;
        if (cyc >= limit) begin
            $display("timeout after %0d cycles, test %0d got %0d of %0d instructions",
                     cyc, stim[cur_t*nf], ndone, stim[cur_t*nf+18]);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int k;
        rnd               = 32'd39654;
        cyc               = 0;
        cur_t             = 0;
        chk_t             = 0;
        ndone             = 0;
        checks            = 0;
        errors            = 0;
        in_new            = 1'b0;
        want_first        = 1'b0;
        redir_now         = 1'b0;
        prev_resetn       = 1'b0;
        lat               = 2'd0;
        last_pc           = fetch_pkg::reset_pc;
        inst_sram_addr_ok = 1'b0;
        inst_sram_data_ok = 1'b0;
        inst_sram_rdata   = '0;
        id_allowin        = 1'b1;
        br_taken          = 1'b0;
        br_target         = '0;
        br_stall          = 1'b0;
        flush             = 1'b0;
        flush_entry       = '0;
        $readmemh("verif/fetch_input.txt", stim);
        apply_settings(0);
        limit = 200;
        for (k = 0; k < ntests; k++) begin
            limit += 8 * stim[k*nf+18];
        end
        while (!resetn) step_cycle();
        for (k = 0; k < ntests; k++) begin
            run_test(k);
        end
        $display("tests %0d, checks %0d, errors %0d", ntests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    initial begin
        resetn = 1'b0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;           // released on the 10th rising edge
    end

endmodule
